// File: design/simd_alu_consts.svh
`ifndef SIMD_ALU_CONSTS_SVH
`define SIMD_ALU_CONSTS_SVH

`define SIMD_ALU_DATA_W   32
`define SIMD_ALU_SHAMT_W  5
`define SIMD_ALU_MUL_LAST 2    // Counter value when the product is taken

// Instruction format byte, ctrl[31:24]
`define ALU_FMT_VOP1  8'h01
`define ALU_FMT_VOP2  8'h02
`define ALU_FMT_VOPC  8'h04
`define ALU_FMT_VOP3A 8'h08

// VOP1 / VOP2 opcodes, ctrl[11:0]
`define ALU_OPC_V_CNDMASK_B32  12'h000
`define ALU_OPC_V_MOV_B32      12'h001
`define ALU_OPC_V_MIN_U32      12'h013
`define ALU_OPC_V_MAX_U32      12'h014
`define ALU_OPC_V_LSHRREV_B32  12'h016
`define ALU_OPC_V_LSHLREV_B32  12'h01A
`define ALU_OPC_V_AND_B32      12'h01B
`define ALU_OPC_V_OR_B32       12'h01C
`define ALU_OPC_V_ADD_I32      12'h025
`define ALU_OPC_V_SUB_I32      12'h026

// Compares, same values in VOPC and VOP3A
`define ALU_OPC_V_CMP_F_I32    12'h080
`define ALU_OPC_V_CMP_LT_I32   12'h081
`define ALU_OPC_V_CMP_EQ_I32   12'h082
`define ALU_OPC_V_CMP_LE_I32   12'h083
`define ALU_OPC_V_CMP_GT_I32   12'h084
`define ALU_OPC_V_CMP_LG_I32   12'h085
`define ALU_OPC_V_CMP_GE_I32   12'h086
`define ALU_OPC_V_CMP_TRU_I32  12'h087
`define ALU_OPC_V_CMP_F_U32    12'h0C0
`define ALU_OPC_V_CMP_LT_U32   12'h0C1
`define ALU_OPC_V_CMP_EQ_U32   12'h0C2
`define ALU_OPC_V_CMP_LE_U32   12'h0C3
`define ALU_OPC_V_CMP_GT_U32   12'h0C4
`define ALU_OPC_V_CMP_LG_U32   12'h0C5
`define ALU_OPC_V_CMP_GE_U32   12'h0C6
`define ALU_OPC_V_CMP_TRU_U32  12'h0C7

// VOP3A only
`define ALU_OPC_V_MIN_U32_VOP3A 12'h113
`define ALU_OPC_V_MAX_U32_VOP3A 12'h114
`define ALU_OPC_V_AND_B32_VOP3A 12'h11B
`define ALU_OPC_V_BFE_U32       12'h148
`define ALU_OPC_V_BFI_B32       12'h14A
`define ALU_OPC_V_MUL_LO_U32    12'h169
`define ALU_OPC_V_MUL_HI_U32    12'h16A

`endif

// File: design/simd_alu_pkg.sv
`include "simd_alu_consts.svh"

package simd_alu_pkg;

  typedef struct packed {
    logic [7:0]  fmt;      // One-hot format code
    logic [11:0] rsvd;
    logic [11:0] opcode;
  } alu_ctrl_t;

  typedef struct packed {
    logic [`SIMD_ALU_DATA_W-1:0] src1;
    logic [`SIMD_ALU_DATA_W-1:0] src2;
    logic [`SIMD_ALU_DATA_W-1:0] src3;
    logic                        vcc;   // Incoming VCC bit of this lane
    logic                        exec;  // Lane enable
    alu_ctrl_t                   ctrl;
  } alu_req_t;

  typedef struct packed {
    logic [`SIMD_ALU_DATA_W-1:0] vgpr_data;
    logic                        vcc;
    logic                        done;
  } alu_rsp_t;

  // Signed and unsigned F, EQ, LG and TRU behave alike and share a value
  typedef enum logic [4:0] {
    OP_NONE,
    OP_MOV,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_LSHL,
    OP_LSHR,
    OP_MAX,
    OP_MIN,
    OP_CNDMASK,
    OP_CMP_F, OP_CMP_LT_I, OP_CMP_EQ, OP_CMP_LE_I,
    OP_CMP_GT_I, OP_CMP_LG, OP_CMP_GE_I, OP_CMP_TRU,
    OP_CMP_LT_U, OP_CMP_LE_U, OP_CMP_GT_U, OP_CMP_GE_U,
    OP_BFE,
    OP_BFI,
    OP_MUL_LO,
    OP_MUL_HI
  } alu_op_e;

endpackage

// File: design/alu_op_decoder.sv
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module alu_op_decoder (
  input  logic                    exec,
  input  simd_alu_pkg::alu_ctrl_t ctrl,
  output simd_alu_pkg::alu_op_e   op
);
  import simd_alu_pkg::*;

  // Compare opcodes are shared by the VOPC and VOP3A encodings
  function automatic alu_op_e cmp_op(input logic [11:0] opc);
    alu_op_e res;
    case (opc)
      `ALU_OPC_V_CMP_F_I32,
      `ALU_OPC_V_CMP_F_U32:   res = OP_CMP_F;
      `ALU_OPC_V_CMP_LT_I32:  res = OP_CMP_LT_I;
      `ALU_OPC_V_CMP_EQ_I32,
      `ALU_OPC_V_CMP_EQ_U32:  res = OP_CMP_EQ;
      `ALU_OPC_V_CMP_LE_I32:  res = OP_CMP_LE_I;
      `ALU_OPC_V_CMP_GT_I32:  res = OP_CMP_GT_I;
      `ALU_OPC_V_CMP_LG_I32,
      `ALU_OPC_V_CMP_LG_U32:  res = OP_CMP_LG;
      `ALU_OPC_V_CMP_GE_I32:  res = OP_CMP_GE_I;
      `ALU_OPC_V_CMP_TRU_I32,
      `ALU_OPC_V_CMP_TRU_U32: res = OP_CMP_TRU;
      `ALU_OPC_V_CMP_LT_U32:  res = OP_CMP_LT_U;
      `ALU_OPC_V_CMP_LE_U32:  res = OP_CMP_LE_U;
      `ALU_OPC_V_CMP_GT_U32:  res = OP_CMP_GT_U;
      `ALU_OPC_V_CMP_GE_U32:  res = OP_CMP_GE_U;
      default:                res = OP_NONE;
    endcase
    return res;
  endfunction

  always_comb
  begin
    op = OP_NONE;  // Lane off or unknown pair
    if (exec)
    begin
      case (ctrl.fmt)
        `ALU_FMT_VOP1:
        begin
          if (ctrl.opcode == `ALU_OPC_V_MOV_B32)
            op = OP_MOV;
        end
        `ALU_FMT_VOP2:
        begin
          case (ctrl.opcode)
            `ALU_OPC_V_CNDMASK_B32: op = OP_CNDMASK;
            `ALU_OPC_V_MIN_U32:     op = OP_MIN;
            `ALU_OPC_V_MAX_U32:     op = OP_MAX;
            `ALU_OPC_V_LSHRREV_B32: op = OP_LSHR;
            `ALU_OPC_V_LSHLREV_B32: op = OP_LSHL;
            `ALU_OPC_V_AND_B32:     op = OP_AND;
            `ALU_OPC_V_OR_B32:      op = OP_OR;
            `ALU_OPC_V_ADD_I32:     op = OP_ADD;
            `ALU_OPC_V_SUB_I32:     op = OP_SUB;
            default:                op = OP_NONE;
          endcase
        end
        `ALU_FMT_VOPC:
          op = cmp_op(ctrl.opcode);
        `ALU_FMT_VOP3A:
        begin
          case (ctrl.opcode)
            `ALU_OPC_V_MIN_U32_VOP3A: op = OP_MIN;
            `ALU_OPC_V_MAX_U32_VOP3A: op = OP_MAX;
            `ALU_OPC_V_AND_B32_VOP3A: op = OP_AND;
            `ALU_OPC_V_BFE_U32:       op = OP_BFE;
            `ALU_OPC_V_BFI_B32:       op = OP_BFI;
            `ALU_OPC_V_MUL_LO_U32:    op = OP_MUL_LO;
            `ALU_OPC_V_MUL_HI_U32:    op = OP_MUL_HI;
            default:                  op = cmp_op(ctrl.opcode);  // VOP3A compares
          endcase
        end
        default:
          op = OP_NONE;
      endcase
    end
  end

endmodule

// File: design/alu_int_unit.sv
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module alu_int_unit (
  input  simd_alu_pkg::alu_op_e          op,
  input  logic [`SIMD_ALU_DATA_W-1:0]    src1,
  input  logic [`SIMD_ALU_DATA_W-1:0]    src2,
  input  logic [`SIMD_ALU_DATA_W-1:0]    src3,
  input  logic                           vcc_in,
  input  logic [2*`SIMD_ALU_DATA_W-1:0]  product,
  input  logic                           mul_done,
  output simd_alu_pkg::alu_rsp_t         rsp
);
  import simd_alu_pkg::*;

  localparam int DW = `SIMD_ALU_DATA_W;
  localparam int SW = `SIMD_ALU_SHAMT_W;

  logic [DW:0]   sum;       // Bit DW is the carry
  logic [DW:0]   diff;      // Bit DW is the borrow
  logic [SW-1:0] sh_amt;
  logic [SW-1:0] bfe_off;
  logic [SW-1:0] bfe_len;
  logic [DW-1:0] bfe_mask;
  logic          lt_s;
  logic          lt_u;
  logic          eq;

  assign sum  = {1'b0, src1} + {1'b0, src2};
  assign diff = {1'b0, src1} - {1'b0, src2};

  assign sh_amt  = src1[SW-1:0];
  assign bfe_off = src2[SW-1:0];
  assign bfe_len = src3[SW-1:0];
  // Length zero selects no bits
  assign bfe_mask = (DW'(1) << bfe_len) - DW'(1);

  assign lt_s = $signed(src1) < $signed(src2);
  assign lt_u = src1 < src2;
  assign eq   = src1 == src2;

  always_comb
  begin
    rsp.vgpr_data = '0;
    rsp.vcc       = vcc_in;           // Untouched unless the op writes VCC
    rsp.done      = (op != OP_NONE);
    case (op)
      OP_MOV:     rsp.vgpr_data = src1;
      OP_ADD:
      begin
        rsp.vgpr_data = sum[DW-1:0];
        rsp.vcc       = sum[DW];
      end
      OP_SUB:
      begin
        rsp.vgpr_data = diff[DW-1:0];
        rsp.vcc       = diff[DW];
      end
      OP_AND:     rsp.vgpr_data = src1 & src2;
      OP_OR:      rsp.vgpr_data = src1 | src2;
      OP_LSHL:    rsp.vgpr_data = src2 << sh_amt;   // Reversed operand order
      OP_LSHR:    rsp.vgpr_data = src2 >> sh_amt;
      OP_MAX:     rsp.vgpr_data = lt_u ? src2 : src1;
      OP_MIN:     rsp.vgpr_data = lt_u ? src1 : src2;
      OP_CNDMASK: rsp.vgpr_data = vcc_in ? src2 : src1;
      OP_CMP_F:    rsp.vcc = 1'b0;
      OP_CMP_LT_I: rsp.vcc = lt_s;
      OP_CMP_EQ:   rsp.vcc = eq;
      OP_CMP_LE_I: rsp.vcc = lt_s | eq;
      OP_CMP_GT_I: rsp.vcc = ~(lt_s | eq);
      OP_CMP_LG:   rsp.vcc = ~eq;
      OP_CMP_GE_I: rsp.vcc = ~lt_s;
      OP_CMP_TRU:  rsp.vcc = 1'b1;
      OP_CMP_LT_U: rsp.vcc = lt_u;
      OP_CMP_LE_U: rsp.vcc = lt_u | eq;
      OP_CMP_GT_U: rsp.vcc = ~(lt_u | eq);
      OP_CMP_GE_U: rsp.vcc = ~lt_u;
      OP_BFE:     rsp.vgpr_data = (src1 >> bfe_off) & bfe_mask;
      OP_BFI:     rsp.vgpr_data = (src1 & src2) | (~src1 & src3);
      OP_MUL_LO:
      begin
        rsp.vgpr_data = product[DW-1:0];
        rsp.done      = mul_done;
      end
      OP_MUL_HI:
      begin
        rsp.vgpr_data = product[2*DW-1:DW];
        rsp.done      = mul_done;
      end
      default:    rsp.vgpr_data = '0;    // OP_NONE
    endcase
  end

endmodule

// File: design/alu_mul_unit.sv
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module alu_mul_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  simd_alu_pkg::alu_op_e          op,
  input  logic [`SIMD_ALU_DATA_W-1:0]    src1,
  input  logic [`SIMD_ALU_DATA_W-1:0]    src2,
  output logic [2*`SIMD_ALU_DATA_W-1:0]  product,
  output logic                           mul_done
);
  import simd_alu_pkg::*;

  localparam int          DW       = `SIMD_ALU_DATA_W;
  localparam logic [1:0]  MUL_LAST = 2'(`SIMD_ALU_MUL_LAST);

  logic       is_mul;
  logic [1:0] cnt;     // Cycles spent on the held multiply

  assign is_mul = (op == OP_MUL_LO) || (op == OP_MUL_HI);

  // Full unsigned product, forced to zero for other ops
  assign product = is_mul ? ({{DW{1'b0}}, src1} * {{DW{1'b0}}, src2}) : '0;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      cnt <= 2'd0;
    else if (!is_mul)
      cnt <= 2'd0;                 // Any other op restarts the count
    else if (cnt == MUL_LAST)
      cnt <= 2'd0;                 // Wrap so a held request repeats
    else
      cnt <= cnt + 2'd1;
  end

  assign mul_done = (cnt == MUL_LAST);

endmodule

// File: design/simd_alu.sv
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu (
  input  logic                   clk,
  input  logic                   rst,
  input  simd_alu_pkg::alu_req_t req,
  output simd_alu_pkg::alu_rsp_t rsp
);
  import simd_alu_pkg::*;

  alu_op_e                        op;
  logic [2*`SIMD_ALU_DATA_W-1:0]  product;
  logic                           mul_done;

  alu_op_decoder i_decoder (
    .exec (req.exec),
    .ctrl (req.ctrl),
    .op   (op)
  );

  alu_mul_unit i_mul (
    .clk      (clk),
    .rst      (rst),
    .op       (op),
    .src1     (req.src1),
    .src2     (req.src2),
    .product  (product),
    .mul_done (mul_done)
  );

  alu_int_unit i_int (
    .op       (op),
    .src1     (req.src1),
    .src2     (req.src2),
    .src3     (req.src3),
    .vcc_in   (req.vcc),
    .product  (product),
    .mul_done (mul_done),
    .rsp      (rsp)
  );

endmodule

// File: dv/simd_alu_tb.sv
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_tb;
  import simd_alu_pkg::*;

  localparam int DW         = `SIMD_ALU_DATA_W;
  localparam int SW         = `SIMD_ALU_SHAMT_W;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int N_OFF      = 50;   // Per half of the first test
  localparam int N_LOGIC    = 40;   // Per logic op encoding
  localparam int N_ARITH    = 60;
  localparam int N_CMP      = 12;   // Per compare encoding
  localparam int N_MUL      = 10;   // Eleven cycles each
  localparam int TOTAL_CYCLES = RST_CYCLES + 2 * N_OFF + 13 * N_LOGIC + 2 * N_ARITH
                                + 32 * N_CMP + 2 * N_MUL * 11;

  // Format and opcode pairs of the single-cycle logic ops
  localparam logic [19:0] LOGIC_OPS [13] = '{
    {`ALU_FMT_VOP1,  `ALU_OPC_V_MOV_B32},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_AND_B32},
    {`ALU_FMT_VOP3A, `ALU_OPC_V_AND_B32_VOP3A},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_OR_B32},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_LSHLREV_B32},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_LSHRREV_B32},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_MAX_U32},
    {`ALU_FMT_VOP3A, `ALU_OPC_V_MAX_U32_VOP3A},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_MIN_U32},
    {`ALU_FMT_VOP3A, `ALU_OPC_V_MIN_U32_VOP3A},
    {`ALU_FMT_VOP2,  `ALU_OPC_V_CNDMASK_B32},
    {`ALU_FMT_VOP3A, `ALU_OPC_V_BFE_U32},
    {`ALU_FMT_VOP3A, `ALU_OPC_V_BFI_B32}
  };

  logic     clk = 1'b0;
  logic     rst;
  alu_req_t req;
  alu_rsp_t rsp;
  int       seed = 32'ha8dd_3efc;
  int       chk_cnt = 0;
  int       err_cnt = 0;
  int       test_chk0;
  int       test_err0;

  simd_alu i_dut (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [DW-1:0] rand_word();
    return $random(seed);
  endfunction

  // Mostly corner values, sometimes random
  function automatic logic [DW-1:0] edge_word();
    logic [DW-1:0] w;
    w = rand_word();
    case (w[1:0])
      2'd0:    w = '1;
      2'd1:    w = '0;
      2'd2:    w = {1'b1, {(DW-1){1'b0}}};
      default: w = rand_word();
    endcase
    return w;
  endfunction

  function automatic alu_req_t make_req(input logic [7:0] fmt, input logic [11:0] opc,
                                        input logic [DW-1:0] a, input logic [DW-1:0] b);
    alu_req_t r;
    logic [DW-1:0] w;
    w = rand_word();
    r.src1 = a;
    r.src2 = b;
    r.src3 = rand_word();
    r.vcc = w[0];
    r.exec = 1'b1;
    r.ctrl.fmt = fmt;
    r.ctrl.rsvd = w[12:1];     // Reserved bits carry noise
    r.ctrl.opcode = opc;
    return r;
  endfunction

  // Expected response, decoded straight from format and opcode
  function automatic alu_rsp_t model(input alu_req_t r, input logic mul_ready);
    alu_rsp_t e;
    logic [DW:0] wide;
    logic [2*DW-1:0] prod;
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    logic [DW-1:0] c;
    logic [11:0] opc;
    logic v1, v2, vc, v3;
    logic lt, eq, gt;
    a = r.src1;
    b = r.src2;
    c = r.src3;
    opc = r.ctrl.opcode;
    v1 = (r.ctrl.fmt == `ALU_FMT_VOP1);
    v2 = (r.ctrl.fmt == `ALU_FMT_VOP2);
    vc = (r.ctrl.fmt == `ALU_FMT_VOPC);
    v3 = (r.ctrl.fmt == `ALU_FMT_VOP3A);
    prod = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
    eq = (a == b);
    lt = opc[6] ? (a < b) : ($signed(a) < $signed(b));  // Bit 6 marks the unsigned group
    gt = !lt && !eq;
    e.vgpr_data = '0;
    e.vcc = r.vcc;
    e.done = 1'b1;
    if (!r.exec)
      e.done = 1'b0;
    else if (v1 && opc == `ALU_OPC_V_MOV_B32)
      e.vgpr_data = a;
    else if (v2 && (opc == `ALU_OPC_V_ADD_I32 || opc == `ALU_OPC_V_SUB_I32))
    begin
      wide = (opc == `ALU_OPC_V_ADD_I32) ? {1'b0, a} + {1'b0, b} : {1'b0, a} - {1'b0, b};
      e.vgpr_data = wide[DW-1:0];
      e.vcc = wide[DW];
    end
    else if ((v2 && opc == `ALU_OPC_V_AND_B32) || (v3 && opc == `ALU_OPC_V_AND_B32_VOP3A))
      e.vgpr_data = a & b;
    else if (v2 && opc == `ALU_OPC_V_OR_B32)
      e.vgpr_data = a | b;
    else if (v2 && opc == `ALU_OPC_V_LSHLREV_B32)
      e.vgpr_data = b << a[SW-1:0];
    else if (v2 && opc == `ALU_OPC_V_LSHRREV_B32)
      e.vgpr_data = b >> a[SW-1:0];
    else if ((v2 && opc == `ALU_OPC_V_MAX_U32) || (v3 && opc == `ALU_OPC_V_MAX_U32_VOP3A))
      e.vgpr_data = (a > b) ? a : b;
    else if ((v2 && opc == `ALU_OPC_V_MIN_U32) || (v3 && opc == `ALU_OPC_V_MIN_U32_VOP3A))
      e.vgpr_data = (a < b) ? a : b;
    else if (v2 && opc == `ALU_OPC_V_CNDMASK_B32)
      e.vgpr_data = r.vcc ? b : a;
    else if ((vc || v3) && opc[11:7] == 5'b00001 && opc[5:3] == 3'b000)
      e.vcc = (opc[0] & lt) | (opc[1] & eq) | (opc[2] & gt);  // LT, EQ, GT bits
    else if (v3 && opc == `ALU_OPC_V_BFE_U32)
      e.vgpr_data = (a >> b[SW-1:0]) & ((DW'(1) << c[SW-1:0]) - DW'(1));
    else if (v3 && opc == `ALU_OPC_V_BFI_B32)
      e.vgpr_data = (a & b) | (~a & c);
    else if (v3 && (opc == `ALU_OPC_V_MUL_LO_U32 || opc == `ALU_OPC_V_MUL_HI_U32))
    begin
      e.vgpr_data = (opc == `ALU_OPC_V_MUL_LO_U32) ? prod[DW-1:0] : prod[2*DW-1:DW];
      e.done = mul_ready;
    end
    else
      e.done = 1'b0;              // Unknown pair
    return e;
  endfunction

  // One request for one cycle, checked mid-cycle
  task automatic step(input alu_req_t r, input logic mul_ready, input logic data_valid);
    alu_rsp_t exp;
    @(posedge clk);
    req <= r;
    @(negedge clk);
    exp = model(r, mul_ready);
    chk_cnt++;
    assert (rsp.done === exp.done)
    else
    begin
      $display("Mismatch rsp.done: expected %h, got %h", exp.done, rsp.done);
      err_cnt++;
    end
    assert (rsp.vcc === exp.vcc)
    else
    begin
      $display("Mismatch rsp.vcc: expected %h, got %h", exp.vcc, rsp.vcc);
      err_cnt++;
    end
    assert (!data_valid || rsp.vgpr_data === exp.vgpr_data)
    else
    begin
      $display("Mismatch rsp.vgpr_data: expected %h, got %h", exp.vgpr_data, rsp.vgpr_data);
      err_cnt++;
    end
  endtask

  task automatic start_test();
    test_chk0 = chk_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic end_test(input string name);
    $display("%-10s checks %0d, errors %0d", name, chk_cnt - test_chk0, err_cnt - test_err0);
  endtask

  task automatic run_mul(input logic [11:0] opc);
    alu_req_t r;
    for (int n = 0; n < N_MUL; n++)
    begin
      r = make_req(`ALU_FMT_VOP3A, opc, rand_word(), rand_word());
      // Two full rounds, then one cycle into a third
      for (int k = 0; k < 7; k++)
        step(r, (k % 3) == 2, (k % 3) == 2);
      // A single other op mid-count restarts the multiplier
      step(make_req(`ALU_FMT_VOP1, `ALU_OPC_V_MOV_B32, rand_word(), rand_word()), 1'b0, 1'b1);
      for (int k = 0; k < 3; k++)
        step(r, k == 2, k == 2);
    end
  endtask

  initial
  begin
    alu_req_t r;
    logic [DW-1:0] w;
    logic [DW-1:0] a;
    logic [11:0] opc;
    rst = 1'b1;
    req = '0;                     // EXEC low through reset
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    start_test();
    for (int n = 0; n < 2 * N_OFF; n++)
    begin
      w = rand_word();
      r = make_req(w[7:0], w[19:8], rand_word(), rand_word());
      if (n < N_OFF)
        r.exec = 1'b0;
      else
        r.ctrl.opcode[11] = 1'b1;   // No opcode has bit 11 set
      step(r, 1'b0, 1'b1);
    end
    end_test("exec_off");

    start_test();
    for (int i = 0; i < 13; i++)
    begin
      for (int n = 0; n < N_LOGIC; n++)
      begin
        r = make_req(LOGIC_OPS[i][19:12], LOGIC_OPS[i][11:0], rand_word(), rand_word());
        step(r, 1'b0, 1'b1);
      end
    end
    end_test("logic");

    start_test();
    for (int n = 0; n < N_ARITH; n++)
    begin
      step(make_req(`ALU_FMT_VOP2, `ALU_OPC_V_ADD_I32, edge_word(), edge_word()), 1'b0, 1'b1);
      step(make_req(`ALU_FMT_VOP2, `ALU_OPC_V_SUB_I32, edge_word(), edge_word()), 1'b0, 1'b1);
    end
    end_test("add_sub");

    start_test();
    for (int k = 0; k < 32; k++)
    begin
      opc = (k % 16 < 8) ? `ALU_OPC_V_CMP_F_I32 + 12'(k % 8) : `ALU_OPC_V_CMP_F_U32 + 12'(k % 8);
      for (int n = 0; n < N_CMP; n++)
      begin
        a = edge_word();
        r = make_req((k < 16) ? `ALU_FMT_VOPC : `ALU_FMT_VOP3A, opc, a,
                     (n % 3 == 0) ? a : edge_word());   // Every third pair is equal
        step(r, 1'b0, 1'b1);
      end
    end
    end_test("compare");

    start_test();
    run_mul(`ALU_OPC_V_MUL_LO_U32);
    run_mul(`ALU_OPC_V_MUL_HI_U32);
    end_test("multiply");

    $display("Total checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #((TOTAL_CYCLES + 100) * CLK_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/simd_alu_pkg.sv
design/alu_op_decoder.sv
design/alu_int_unit.sv
design/alu_mul_unit.sv
design/simd_alu.sv
dv/simd_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the simd_alu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
  --top-module simd_alu_tb -o simd_alu_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simd_alu_sim > sim.log 2>&1
cat sim.log

grep -q "^Simulation completed successfully$" sim.log && exit 0 || exit 1
